// File: bench/cru_cases.txt
# kind name a b c expected (decimal)
# order: gap | wdt/swb: hold latency gap | dom: domain delay | div: D W ticks | gate: gate D W ticks
order   order_boot    0   0   0   16
wdt     wdt_hold_8    8   3   0   16
wdt     wdt_hold_40   40  3   0   16
swb     swb_hold_6    6   3   0   16
swb     swb_hold_25   25  3   0   16
dom     dom_per       0   0   0   2
dom     dom_ddr       1   0   0   2
dom     dom_usb       2   0   0   2
dom     dom_dma       3   0   0   2
div     div_0         0   32  0   32
div     div_1         1   40  0   20
div     div_3         3   64  0   16
div     div_7         7   96  0   12
div     div_15        15  96  0   6
gate    gate_qspi     0   1   40  20
gate    gate_uart     2   3   48  12
gate    gate_gpio     3   0   20  20
order   order_again   0   0   0   16

// File: project.f
rtl/cru_pkg.sv
rtl/rst_domain_pkg.sv
rtl/rst_sync.sv
rtl/cdc_sync.sv
rtl/bcpu_rst_seq.sv
rtl/periph_rst_ctl.sv
rtl/periph_clk_div.sv
rtl/cru_top.sv
bench/tb_cru_top.sv

// File: Bender.yml
package:
  name: cru_top

sources:
  - rtl/cru_pkg.sv
  - rtl/rst_domain_pkg.sv
  - rtl/rst_sync.sv
  - rtl/cdc_sync.sv
  - rtl/bcpu_rst_seq.sv
  - rtl/periph_rst_ctl.sv
  - rtl/periph_clk_div.sv
  - rtl/cru_top.sv
  - target: simulation
    files:
      - bench/tb_cru_top.sv

// File: bench/tb_cru_top.sv
`timescale 1ns/100ps

module tb_cru_top;

  logic                        clk_int0;
  logic                        rst_n_266;
  logic                        bcpu_wdt_rst;
  logic                        sw_bcpu_rstn;
  rst_domain_pkg::domain_vec_t sw_rstn;
  rst_domain_pkg::gate_vec_t   gate_en;
  cru_pkg::div_t               div_value;
  logic                        cfg_lock;
  logic                        rst_n_bcpu_bus;
  logic                        rst_n_bcpu_core;
  logic                        bcpu_rst_done;
  rst_domain_pkg::domain_vec_t rst_n_periph;
  rst_domain_pkg::gate_vec_t   tick_periph;

  // Case lines, parsed again when each case runs
  string  line_q[$];
  integer seed;
  int     errors;
  int     checks;
  int     cycles;
  int     cycle_limit;

  cru_top i_cru_top (.*);

  always #2 clk_int0 = ~clk_int0;

  always @(posedge clk_int0) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic check(input string name, input int actual, input int expected);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("** Error @ %0t ns: %s got %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  task automatic apply_reset();
    rst_n_266 = 1'b0;
    repeat (16) @(negedge clk_int0);
    rst_n_266 = 1'b1;
  endtask

  // ********************************************************************
  // BCPU reset sequence
  // ********************************************************************

  // Bus first, core later, done high only in the core release cycle
  task automatic release_gap(input string name, input int expected);
    int gap;
    gap = 0;
    while (!rst_n_bcpu_bus) @(negedge clk_int0);
    check(name, rst_n_bcpu_core, 0);
    while (!rst_n_bcpu_core) begin
      @(negedge clk_int0);
      gap++;
    end
    check(name, gap, expected);
    check(name, bcpu_rst_done, 1);
    @(negedge clk_int0);
    check(name, bcpu_rst_done, 0);
  endtask

  // Watchdog request when wdt is set, software request otherwise
  task automatic bcpu_request(input string name, input bit wdt, input int hold,
                              input int latency, input int expected);
    int lat;
    lat = 0;
    bcpu_wdt_rst = wdt;
    sw_bcpu_rstn = wdt;
    while (rst_n_bcpu_bus || rst_n_bcpu_core) begin
      @(negedge clk_int0);
      lat++;
    end
    check(name, lat, latency);
    // Both stay in reset for the rest of the hold
    repeat (hold - lat) begin
      @(negedge clk_int0);
      check(name, rst_n_bcpu_bus || rst_n_bcpu_core, 0);
    end
    bcpu_wdt_rst = 1'b0;
    sw_bcpu_rstn = 1'b1;
    release_gap(name, expected);
  endtask

  // ********************************************************************
  // Peripheral resets and ticks
  // ********************************************************************

  task automatic domain_reset(input string name, input int d, input int expected);
    rst_domain_pkg::domain_vec_t others;
    int rel;
    rel = 0;
    others = ~(rst_domain_pkg::domain_vec_t'(1) << d);
    sw_rstn = others;
    // Async assert, seen before the next clock edge
    #1;
    check(name, rst_n_periph, others);
    repeat (3) begin
      @(negedge clk_int0);
      check(name, rst_n_periph, others);
    end
    sw_rstn = '1;
    while (!rst_n_periph[d]) begin
      @(negedge clk_int0);
      rel++;
      check(name, rst_n_periph & others, others);
    end
    check(name, rel, expected);
  endtask

  // Divisor d under lock, one gate off when gate is not negative
  task automatic tick_window(input string name, input int gate, input int d, input int w,
                             input int expected);
    int cnt [rst_domain_pkg::NUM_GATES];
    cnt = '{default: 0};
    cfg_lock = 1'b0;
    div_value = cru_pkg::div_t'(d);
    gate_en = '1;
    // Long enough for the old count to run out
    repeat (20) @(negedge clk_int0);
    cfg_lock = 1'b1;
    @(negedge clk_int0);
    // New register value behind the lock
    div_value = ~cru_pkg::div_t'(d);
    if (gate >= 0) begin
      gate_en[gate] = 1'b0;
    end
    repeat (cru_pkg::SYNC_STAGES) @(negedge clk_int0);
    repeat (w) begin
      foreach (cnt[i]) cnt[i] += tick_periph[i];
      @(negedge clk_int0);
    end
    foreach (cnt[i]) check(name, cnt[i], (i == gate) ? 0 : expected);
    gate_en = '1;
  endtask

  initial begin
    int    fd;
    string line;
    string kind;
    string name;
    int    a;
    int    b;
    int    c;
    int    e;
    seed = 32'h93c3_82cf;
    clk_int0 = 1'b0;
    rst_n_266 = 1'b0;
    bcpu_wdt_rst = 1'b0;
    sw_bcpu_rstn = 1'b1;
    sw_rstn = '1;
    gate_en = '1;
    div_value = cru_pkg::div_t'(1);
    cfg_lock = 1'b0;
    fd = $fopen("bench/cru_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the case file bench/cru_cases.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line[0] != "#" &&
            $sscanf(line, "%s %s %d %d %d %d", kind, name, a, b, c, e) == 6) begin
          line_q.push_back(line);
        end
      end
      $fclose(fd);
    end
    // Every case finishes well inside 200 cycles
    cycle_limit = line_q.size() * 200 + 100;
    apply_reset();
    while (!rst_n_bcpu_core) @(negedge clk_int0);
    foreach (line_q[i]) begin
      void'($sscanf(line_q[i], "%s %s %d %d %d %d", kind, name, a, b, c, e));
      case (kind)
        "order": begin
          apply_reset();
          release_gap(name, e);
        end
        "wdt":   bcpu_request(name, 1'b1, a, b, e);
        "swb":   bcpu_request(name, 1'b0, a, b, e);
        "dom":   domain_reset(name, a, e);
        "div":   tick_window(name, -1, a, b, e);
        "gate":  tick_window(name, a, b, c, e);
        default: begin
          errors++;
          $display("Unknown case kind %s in the case file", kind);
        end
      endcase
      // Idle gap of 1 to 4 cycles
      repeat (1 + $unsigned($random(seed)) % 4) @(negedge clk_int0);
    end
    $display("Ran %0d cases, %0d checks, %0d errors", line_q.size(), checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: rtl/cru_top.sv
`timescale 1ns/100ps

module cru_top #(
  parameter int STAGES = cru_pkg::SYNC_STAGES
) (
  input  logic                        clk_int0,
  input  logic                        rst_n_266,
  // BCPU reset requests
  input  logic                        bcpu_wdt_rst,
  input  logic                        sw_bcpu_rstn,
  // Register-side controls
  input  rst_domain_pkg::domain_vec_t sw_rstn,
  input  rst_domain_pkg::gate_vec_t   gate_en,
  input  cru_pkg::div_t               div_value,
  input  logic                        cfg_lock,
  // BCPU resets
  output logic                        rst_n_bcpu_bus,
  output logic                        rst_n_bcpu_core,
  output logic                        bcpu_rst_done,
  // Peripheral resets and tick enables
  output rst_domain_pkg::domain_vec_t rst_n_periph,
  output rst_domain_pkg::gate_vec_t   tick_periph
);

  // Chip reset after synchronous release
  logic rst_n_sys;

  // ********************************************************************
  // Reset source
  // ********************************************************************

  rst_sync #(
    .STAGES (STAGES)
  ) i_rst_sync (
    .clk_int0  (clk_int0),
    .rst_n_266 (rst_n_266),
    .rst_n_out (rst_n_sys)
  );

  // ********************************************************************
  // BCPU resets
  // ********************************************************************

  bcpu_rst_seq #(
    .STAGES (STAGES)
  ) i_bcpu_rst_seq (
    .clk_int0        (clk_int0),
    .rst_n_266       (rst_n_sys),
    .bcpu_wdt_rst    (bcpu_wdt_rst),
    .sw_bcpu_rstn    (sw_bcpu_rstn),
    .rst_n_bcpu_bus  (rst_n_bcpu_bus),
    .rst_n_bcpu_core (rst_n_bcpu_core),
    .bcpu_rst_done   (bcpu_rst_done)
  );

  // ********************************************************************
  // Peripheral resets and clock enables
  // ********************************************************************

  periph_rst_ctl #(
    .STAGES (STAGES)
  ) i_periph_rst_ctl (
    .clk_int0     (clk_int0),
    .rst_n_266    (rst_n_sys),
    .sw_rstn      (sw_rstn),
    .rst_n_periph (rst_n_periph)
  );

  periph_clk_div #(
    .STAGES (STAGES)
  ) i_periph_clk_div (
    .clk_int0    (clk_int0),
    .rst_n_266   (rst_n_sys),
    .div_value   (div_value),
    .cfg_lock    (cfg_lock),
    .gate_en     (gate_en),
    .tick_periph (tick_periph)
  );

endmodule

// File: rtl/periph_clk_div.sv
`timescale 1ns/100ps

module periph_clk_div #(
  parameter int STAGES = cru_pkg::SYNC_STAGES
) (
  input  logic                      clk_int0,
  input  logic                      rst_n_266,
  input  cru_pkg::div_t             div_value,
  input  logic                      cfg_lock,
  input  rst_domain_pkg::gate_vec_t gate_en,
  output rst_domain_pkg::gate_vec_t tick_periph
);

  cru_pkg::div_t             div_shadow;
  cru_pkg::div_t             div_cnt;
  logic                      tick_raw;
  rst_domain_pkg::gate_vec_t gate_sync;

  // ********************************************************************
  // Divisor shadow
  // ********************************************************************

  // Follows the register while unlocked and freezes under cfg_lock
  always_ff @(posedge clk_int0 or negedge rst_n_266) begin
    if (!rst_n_266) begin
      div_shadow <= cru_pkg::div_t'(1);
    end else if (!cfg_lock) begin
      div_shadow <= div_value;
    end
  end

  // ********************************************************************
  // Tick counter
  // ********************************************************************

  // One tick every div_shadow + 1 cycles
  always_ff @(posedge clk_int0 or negedge rst_n_266) begin
    if (!rst_n_266) begin
      div_cnt  <= '0;
      tick_raw <= 1'b0;
    end else if (div_cnt == '0) begin
      div_cnt  <= div_shadow;
      tick_raw <= 1'b1;
    end else begin
      div_cnt  <= div_cnt - 4'd1;
      tick_raw <= 1'b0;
    end
  end

  // ********************************************************************
  // Per-peripheral gating
  // ********************************************************************

  cdc_sync #(
    .STAGES (STAGES),
    .data_t (rst_domain_pkg::gate_vec_t)
  ) i_gate_sync (
    .clk_int0  (clk_int0),
    .rst_n_266 (rst_n_266),
    .din       (gate_en),
    .dout      (gate_sync)
  );

  // Enables instead of clock gates since all logic stays on clk_int0
  assign tick_periph = {rst_domain_pkg::NUM_GATES{tick_raw}} & gate_sync;

  a_shadow_locked: assert property (
    @(posedge clk_int0) disable iff (!rst_n_266)
    cfg_lock |=> $stable(div_shadow)
  ) else $error("divisor shadow changed under cfg_lock");

endmodule

// File: rtl/periph_rst_ctl.sv
`timescale 1ns/100ps

module periph_rst_ctl #(
  parameter int STAGES = cru_pkg::SYNC_STAGES
) (
  input  logic                        clk_int0,
  input  logic                        rst_n_266,
  input  rst_domain_pkg::domain_vec_t sw_rstn,
  output rst_domain_pkg::domain_vec_t rst_n_periph
);

  rst_domain_pkg::domain_vec_t dom_rst_n;

  // ********************************************************************
  // Domain reset sources
  // ********************************************************************

  // Chip reset or the domain's software bit pulls the domain down
  assign dom_rst_n = {rst_domain_pkg::NUM_DOMAINS{rst_n_266}} & sw_rstn;

  // ********************************************************************
  // Per-domain release
  // ********************************************************************

  // Async assert and release after STAGES clocks
  for (genvar d = 0; d < rst_domain_pkg::NUM_DOMAINS; d++) begin : g_dom
    rst_sync #(
      .STAGES (STAGES)
    ) i_rst_sync (
      .clk_int0  (clk_int0),
      .rst_n_266 (dom_rst_n[d]),
      .rst_n_out (rst_n_periph[d])
    );
  end

endmodule

// File: rtl/bcpu_rst_seq.sv
`timescale 1ns/100ps

module bcpu_rst_seq #(
  parameter int STAGES = cru_pkg::SYNC_STAGES
) (
  input  logic clk_int0,
  input  logic rst_n_266,
  input  logic bcpu_wdt_rst,
  input  logic sw_bcpu_rstn,
  output logic rst_n_bcpu_bus,
  output logic rst_n_bcpu_core,
  output logic bcpu_rst_done
);

  // Last counter values before each release
  localparam cru_pkg::seq_cnt_t BUS_LAST  = cru_pkg::BUS_RELEASE - 8'd1;
  localparam cru_pkg::seq_cnt_t CORE_LAST = cru_pkg::CORE_RELEASE - 8'd1;

  // Cycles between bus and core release
  localparam int REL_GAP = int'(cru_pkg::CORE_RELEASE - cru_pkg::BUS_RELEASE);

  logic              bcpu_req;
  logic              req_sync;
  logic              seq_run;
  cru_pkg::seq_cnt_t seq_cnt;

  // ********************************************************************
  // Request folding
  // ********************************************************************

  // Watchdog or software reset, either one holds the BCPU
  assign bcpu_req = bcpu_wdt_rst | ~sw_bcpu_rstn;

  cdc_sync #(
    .STAGES (STAGES),
    .data_t (logic)
  ) i_req_sync (
    .clk_int0  (clk_int0),
    .rst_n_266 (rst_n_266),
    .din       (bcpu_req),
    .dout      (req_sync)
  );

  // ********************************************************************
  // Release counter
  // ********************************************************************

  // Counting until the core is out of reset
  assign seq_run = ~req_sync & ~rst_n_bcpu_core;

  always_ff @(posedge clk_int0 or negedge rst_n_266) begin
    if (!rst_n_266) begin
      seq_cnt         <= '0;
      rst_n_bcpu_bus  <= 1'b0;
      rst_n_bcpu_core <= 1'b0;
      bcpu_rst_done   <= 1'b0;
    end else if (req_sync) begin
      // Held at zero for as long as the request lasts
      seq_cnt         <= '0;
      rst_n_bcpu_bus  <= 1'b0;
      rst_n_bcpu_core <= 1'b0;
      bcpu_rst_done   <= 1'b0;
    end else if (seq_run) begin
      seq_cnt <= seq_cnt + 8'd1;
      if (seq_cnt == BUS_LAST) begin
        rst_n_bcpu_bus <= 1'b1;
      end
      if (seq_cnt == CORE_LAST) begin
        rst_n_bcpu_core <= 1'b1;
      end
      bcpu_rst_done <= (seq_cnt == CORE_LAST);
    end else begin
      // Sequence finished, counter parked
      bcpu_rst_done <= 1'b0;
    end
  end

  // ********************************************************************
  // Checks
  // ********************************************************************

  a_core_after_bus: assert property (
    @(posedge clk_int0) disable iff (!rst_n_266)
    rst_n_bcpu_core |-> rst_n_bcpu_bus
  ) else $error("BCPU core out of reset while bus still held");

  // Bus must have risen exactly REL_GAP cycles before the core
  a_release_gap: assert property (
    @(posedge clk_int0) disable iff (!rst_n_266)
    $rose(rst_n_bcpu_core) |-> $past(rst_n_bcpu_bus, REL_GAP)
                              && !$past(rst_n_bcpu_bus, REL_GAP + 1)
  ) else $error("BCPU bus to core release gap is wrong");

  a_done_pulse: assert property (
    @(posedge clk_int0) disable iff (!rst_n_266)
    bcpu_rst_done |=> !bcpu_rst_done
  ) else $error("bcpu_rst_done wider than one cycle");

endmodule

// File: rtl/cdc_sync.sv
`timescale 1ns/100ps

module cdc_sync #(
  parameter int  STAGES = cru_pkg::SYNC_STAGES,
  parameter type data_t = logic
) (
  input  logic  clk_int0,
  input  logic  rst_n_266,
  input  data_t din,
  output data_t dout
);

  // Samples of history needed before the output is meaningful
  localparam int HIST = STAGES + 1;

  data_t sync_q [STAGES];

  // Register-side levels have no clock relation to clk_int0
  always_ff @(posedge clk_int0 or negedge rst_n_266) begin
    if (!rst_n_266) begin
      for (int i = 0; i < STAGES; i++) begin
        sync_q[i] <= data_t'(0);
      end
    end else begin
      sync_q[0] <= din;
      for (int i = 1; i < STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign dout = sync_q[STAGES-1];

  // Fixed latency once the chain has filled since reset
  a_fixed_latency: assert property (
    @(posedge clk_int0)
    rst_n_266 [*HIST] |-> dout == $past(din, STAGES)
  ) else $error("cdc_sync output does not match delayed input");

endmodule

// File: rtl/rst_sync.sv
`timescale 1ns/100ps

module rst_sync #(
  parameter int STAGES = cru_pkg::SYNC_STAGES
) (
  input  logic clk_int0,
  input  logic rst_n_266,
  output logic rst_n_out
);

  logic [STAGES-1:0] sync_q;

  // Cleared at once by the async input, ones shift in after release
  always_ff @(posedge clk_int0 or negedge rst_n_266) begin
    if (!rst_n_266) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= 1'b1;
      for (int i = 1; i < STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign rst_n_out = sync_q[STAGES-1];

  // Release only after the source has been high for the full chain depth
  a_release_delay: assert property (
    @(posedge clk_int0)
    $rose(rst_n_out) |-> rst_n_266 && $past(rst_n_266, STAGES)
  ) else $error("rst_sync released before source was stable");

endmodule

// File: rtl/rst_domain_pkg.sv
package rst_domain_pkg;

  // ********************************************************************
  // Peripheral reset domains
  // ********************************************************************

  localparam int NUM_DOMAINS = 4;

  // Bit positions in sw_rstn and rst_n_periph
  typedef enum logic [1:0] {DOM_PER, DOM_DDR, DOM_USB, DOM_DMA} domain_e;

  typedef logic [NUM_DOMAINS-1:0] domain_vec_t;

  // ********************************************************************
  // Gated peripheral ticks
  // ********************************************************************

  localparam int NUM_GATES = 4;

  // Bit positions in gate_en and tick_periph
  typedef enum logic [1:0] {GATE_QSPI, GATE_I2C, GATE_UART, GATE_GPIO} gate_e;

  typedef logic [NUM_GATES-1:0] gate_vec_t;

endpackage

// File: rtl/cru_pkg.sv
package cru_pkg;

  // ********************************************************************
  // Divider settings
  // ********************************************************************

  // Width of a programmable divisor
  localparam int DIV_WIDTH = 4;

  typedef logic [DIV_WIDTH-1:0] div_t;

  // ********************************************************************
  // BCPU reset sequence
  // ********************************************************************

  typedef logic [7:0] seq_cnt_t;

  // Counter value where the bus reset lets go
  localparam seq_cnt_t BUS_RELEASE = 8'd16;

  // Counter value where the core reset lets go, also the end of the sequence
  localparam seq_cnt_t CORE_RELEASE = 8'd32;

  // ********************************************************************
  // Synchronizers
  // ********************************************************************

  // Default flop depth for reset and level synchronizers
  localparam int SYNC_STAGES = 2;

endpackage
